//--- all.f
+incdir+bench
hdl/scene_pkg.sv
hdl/instance_ram.sv
hdl/scene_cursor.sv
hdl/scene_slot_table.sv
hdl/read_sequencer.sv
hdl/scene_buffer.sv
bench/scene_buffer_tb.sv

//--- bench/scene_buffer_checks.svh
`ifndef SCENE_BUFFER_CHECKS_SVH
`define SCENE_BUFFER_CHECKS_SVH

// Cycles any single wait may take
localparam int WAIT_LIMIT = 200;

int errors   = 0;
int timeouts = 0;
// Instances seen leaving the read side
int consumed = 0;

task automatic check_instance(input modelinstance_t actual, input modelinstance_t expected,
                              input string name);
    if (actual !== expected) begin
        errors++;
        $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, actual, expected);
    end
endtask

task automatic check_meta(input modelinstance_meta_t actual,
                          input modelinstance_meta_t expected, input string name);
    if (actual !== expected) begin
        errors++;
        $display("CHECK FAILED at %0t: %s.last is %b, expected %b", $time, name,
                 actual.last, expected.last);
    end
endtask

task automatic check_flag(input logic actual, input logic expected, input string name);
    if (actual !== expected) begin
        errors++;
        $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, name, actual, expected);
    end
endtask

task automatic report_timeout(input string what);
    timeouts++;
    $display("Timeout at %0t: gave up waiting for %s", $time, what);
endtask

// Sampled mid cycle, where write_ready is settled
task automatic wait_write_ready();
    int waited;
    waited = 0;
    @(negedge clk);
    while (!write_ready && waited < WAIT_LIMIT) begin
        @(negedge clk);
        waited++;
    end
    if (!write_ready) begin
        report_timeout("write_ready to go high");
    end
endtask

`endif

//--- bench/scene_buffer_tb.sv
`timescale 1ns/100ps

module scene_buffer_tb
    import scene_pkg::*;
();

    logic                clk;
    logic                rstn;
    logic                write_valid;
    logic                write_ready;
    modelinstance_t      write_data;
    modelinstance_meta_t write_meta;
    logic                read_valid;
    logic                read_ready;
    modelinstance_t      read_data;
    modelinstance_meta_t read_meta;

    // Expected stream in write order
    modelinstance_t      exp_data [$];
    modelinstance_meta_t exp_meta [$];

    logic [31:0] lcg_state = 32'hac817340;

    `include "scene_buffer_checks.svh"

    scene_buffer dut (
        .clk         (clk),
        .rstn        (rstn),
        .write_valid (write_valid),
        .write_ready (write_ready),
        .write_data  (write_data),
        .write_meta  (write_meta),
        .read_valid  (read_valid),
        .read_ready  (read_ready),
        .read_data   (read_data),
        .read_meta   (read_meta)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic random_bit();
        logic [31:0] r;
        r = lcg_next();
        return r[31];
    endfunction

    function automatic modelinstance_t make_instance();
        logic [31:0]    r1;
        logic [31:0]    r2;
        modelinstance_t inst;
        r1 = lcg_next();
        r2 = lcg_next();
        inst.model_id = r1[31:24];
        inst.pos_x    = r1[23:8];
        inst.pos_y    = r2[31:16];
        inst.pos_z    = r2[15:0];
        inst.rot      = r1[7:0];
        return inst;
    endfunction

    // Called 1 ns after a rising edge, returns at the same point
    task automatic write_instance(input modelinstance_t data, input logic last);
        write_valid     = 1'b1;
        write_data      = data;
        write_meta.last = last;
        wait_write_ready();
        @(posedge clk);
        #1;
        write_valid = 1'b0;
    endtask

    task automatic write_scene(input int count, input logic terminate);
        modelinstance_t      inst;
        modelinstance_meta_t meta;
        logic                last;
        for (int i = 0; i < count; i++) begin
            inst = make_instance();
            last = terminate && (i == count - 1);
            // Slot also closes on its final entry
            meta.last = last || (i == TRANSFORM_COUNT - 1);
            exp_data.push_back(inst);
            exp_meta.push_back(meta);
            write_instance(inst, last);
        end
    endtask

    // Checks every instance that leaves, and the hold during a stall
    task automatic monitor_reads();
        modelinstance_t      held_data;
        modelinstance_meta_t held_meta;
        logic                stalled;
        stalled = 1'b0;
        forever begin
            @(negedge clk);
            if (stalled) begin
                check_flag(read_valid, 1'b1, "read_valid during stall");
                check_instance(read_data, held_data, "read_data during stall");
                check_meta(read_meta, held_meta, "read_meta during stall");
            end
            if (read_valid && read_ready) begin
                if (exp_data.size() == 0) begin
                    errors++;
                    $display("Unexpected instance read out at %0t with nothing expected", $time);
                end else begin
                    check_instance(read_data, exp_data.pop_front(), "read_data");
                    check_meta(read_meta, exp_meta.pop_front(), "read_meta");
                end
                consumed++;
            end
            stalled   = read_valid && !read_ready;
            held_data = read_data;
            held_meta = read_meta;
        end
    endtask

    task automatic consume_instances(input int count, input logic random_ready);
        int target;
        int waited;
        target = consumed + count;
        waited = 0;
        while (consumed < target && waited < WAIT_LIMIT) begin
            if (random_ready) begin
                read_ready = random_bit();
            end else begin
                read_ready = 1'b1;
            end
            @(posedge clk);
            #1;
            waited++;
        end
        if (consumed < target) begin
            report_timeout("instances on the read side");
        end
        read_ready = 1'b0;
    endtask

    task automatic test_reset_state();
        check_flag(write_ready, 1'b1, "write_ready");
        check_flag(read_valid, 1'b0, "read_valid");
    endtask

    task automatic test_single_scene();
        fork
            write_scene(5, 1'b1);
            consume_instances(5, 1'b0);
        join
        check_flag(read_valid, 1'b0, "read_valid");
    endtask

    task automatic test_write_stall();
        read_ready = 1'b0;
        write_scene(3, 1'b1);
        write_scene(4, 1'b1);
        check_flag(write_ready, 1'b0, "write_ready");
        fork
            write_scene(6, 1'b1);
            begin
                repeat (3) begin
                    @(negedge clk);
                    check_flag(write_ready, 1'b0, "write_ready");
                end
                @(posedge clk);
                #1;
                consume_instances(3, 1'b0);
                wait_write_ready();
                @(posedge clk);
                #1;
                consume_instances(10, 1'b0);
            end
        join
    endtask

    task automatic test_read_backpressure();
        int          sizes [3];
        int          total;
        logic [31:0] r;
        total = 0;
        for (int i = 0; i < 3; i++) begin
            r = lcg_next();
            sizes[i] = int'(r[30:28]) + 1;
            total += sizes[i];
        end
        fork
            begin
                for (int i = 0; i < 3; i++) begin
                    write_scene(sizes[i], 1'b1);
                end
            end
            consume_instances(total, 1'b1);
        join
    endtask

    task automatic test_capacity_close();
        fork
            write_scene(TRANSFORM_COUNT, 1'b0);
            consume_instances(TRANSFORM_COUNT, 1'b0);
        join
        check_flag(read_valid, 1'b0, "read_valid");
    endtask

    initial begin
        rstn        = 1'b0;
        write_valid = 1'b0;
        write_data  = '0;
        write_meta  = '0;
        read_ready  = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rstn = 1'b1;
        fork
            monitor_reads();
        join_none

        test_reset_state();
        test_single_scene();
        test_write_stall();
        test_read_backpressure();
        test_capacity_close();

        if (exp_data.size() != 0) begin
            errors++;
            $display("%0d written instances never came out", exp_data.size());
        end
        $display("Errors: %0d check failures, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- hdl/instance_ram.sv
`timescale 1ns/100ps

module instance_ram
    import scene_pkg::*;
(
    input  logic           clk,

    input  logic           write_enable,
    input  ram_addr_t      write_address,
    input  modelinstance_t write_data,

    input  logic           read_enable,
    input  ram_addr_t      read_address,
    output modelinstance_t read_data
);

    modelinstance_t mem [ENTRY_COUNT];

    always_ff @(posedge clk) begin
        if (write_enable) begin
            mem[write_address] <= write_data;
        end
    end

    // Output register only loads on a fetch, so data holds under back-pressure
    always_ff @(posedge clk) begin
        if (read_enable) begin
            read_data <= mem[read_address];
        end
    end

endmodule

//--- hdl/read_sequencer.sv
`timescale 1ns/100ps

module read_sequencer
    import scene_pkg::*;
(
    input  logic                clk,
    input  logic                rstn,

    input  logic                read_ready,

    // State of the slot under the read cursor
    input  logic                read_closed,
    input  transform_idx_t      read_size,
    input  transform_idx_t      read_index,

    output logic                fetch,
    output logic                retire,

    output logic                read_valid,
    output modelinstance_meta_t read_meta
);

    typedef enum logic [1:0] {
        st_wait_scene,
        st_stream,
        st_retire
    } state_t;

    state_t state;
    state_t state_next;

    logic remaining;
    logic drained;
    logic fetch_last;

    assign remaining  = read_closed && (read_index < read_size);
    // Every instance fetched, the last one sits in the output register
    assign drained    = read_closed && (read_index == read_size);
    assign fetch_last = (read_index == read_size - transform_idx_t'(1));

    assign fetch  = (state == st_stream) && read_ready && remaining;
    assign retire = (state == st_retire);

    always_comb begin
        state_next = state;
        case (state)
            st_wait_scene: begin
                if (read_closed) begin
                    state_next = st_stream;
                end
            end
            st_stream: begin
                if (!read_closed) begin
                    state_next = st_wait_scene;
                end else if (drained && read_ready) begin
                    state_next = st_retire;
                end
            end
            st_retire: begin
                // Next slot may already be closed, check it in stream
                state_next = st_stream;
            end
            default: begin
                state_next = st_wait_scene;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= st_wait_scene;
        end else begin
            state <= state_next;
        end
    end

    // Output stage follows the RAM read register
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            read_valid     <= 1'b0;
            read_meta.last <= 1'b0;
        end else if (read_ready) begin
            read_valid     <= fetch;
            read_meta.last <= fetch && fetch_last;
        end
    end

endmodule

//--- hdl/scene_buffer.sv
`timescale 1ns/100ps

module scene_buffer
    import scene_pkg::*;
(
    input  logic                clk,
    input  logic                rstn,

    input  logic                write_valid,
    output logic                write_ready,
    input  modelinstance_t      write_data,
    input  modelinstance_meta_t write_meta,

    output logic                read_valid,
    input  logic                read_ready,
    output modelinstance_t      read_data,
    output modelinstance_meta_t read_meta
);

    logic           write_step;
    logic           write_close;
    scene_idx_t     write_slot;
    transform_idx_t write_index;
    ram_addr_t      write_address;

    logic           fetch;
    logic           retire;
    scene_idx_t     read_slot;
    transform_idx_t read_index;
    ram_addr_t      read_address;
    logic           read_closed;
    transform_idx_t read_size;

    scene_cursor write_cursor (
        .clk     (clk),
        .rstn    (rstn),
        .step    (write_step),
        .advance (write_close),
        .slot    (write_slot),
        .index   (write_index),
        .address (write_address)
    );

    scene_cursor read_cursor (
        .clk     (clk),
        .rstn    (rstn),
        .step    (fetch),
        .advance (retire),
        .slot    (read_slot),
        .index   (read_index),
        .address (read_address)
    );

    scene_slot_table slot_table (
        .clk         (clk),
        .rstn        (rstn),
        .write_valid (write_valid),
        .write_meta  (write_meta),
        .write_slot  (write_slot),
        .write_index (write_index),
        .write_ready (write_ready),
        .write_step  (write_step),
        .write_close (write_close),
        .read_slot   (read_slot),
        .retire      (retire),
        .read_closed (read_closed),
        .read_size   (read_size)
    );

    read_sequencer sequencer (
        .clk         (clk),
        .rstn        (rstn),
        .read_ready  (read_ready),
        .read_closed (read_closed),
        .read_size   (read_size),
        .read_index  (read_index),
        .fetch       (fetch),
        .retire      (retire),
        .read_valid  (read_valid),
        .read_meta   (read_meta)
    );

    instance_ram ram (
        .clk           (clk),
        .write_enable  (write_step),
        .write_address (write_address),
        .write_data    (write_data),
        .read_enable   (fetch),
        .read_address  (read_address),
        .read_data     (read_data)
    );

endmodule

//--- hdl/scene_cursor.sv
`timescale 1ns/100ps

module scene_cursor
    import scene_pkg::*;
(
    input  logic           clk,
    input  logic           rstn,

    // One more instance in the current slot
    input  logic           step,
    // Current slot is done, move to the next one
    input  logic           advance,

    output scene_idx_t     slot,
    output transform_idx_t index,
    output ram_addr_t      address
);

    scene_idx_t next_slot;

    always_comb begin
        if (slot == LAST_SCENE) begin
            next_slot = '0;
        end else begin
            next_slot = slot + scene_idx_t'(1);
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            slot  <= '0;
            index <= '0;
        end else begin
            if (advance) begin
                slot  <= next_slot;
                index <= '0;
            end else if (step) begin
                index <= index + transform_idx_t'(1);
            end
        end
    end

    // Slots sit back to back in the RAM
    assign address = ram_addr_t'(slot) * SLOT_STRIDE + ram_addr_t'(index);

endmodule

//--- hdl/scene_pkg.sv
package scene_pkg;

    // Buffer geometry
    localparam int SCENE_COUNT     = 2;
    localparam int TRANSFORM_COUNT = 8;
    localparam int ENTRY_COUNT     = SCENE_COUNT * TRANSFORM_COUNT;

    localparam int SCENE_IDX_WIDTH     = (SCENE_COUNT > 1) ? $clog2(SCENE_COUNT) : 1;
    // Must hold TRANSFORM_COUNT itself, a full slot reports that size
    localparam int TRANSFORM_IDX_WIDTH = $clog2(TRANSFORM_COUNT + 1);
    localparam int RAM_ADDR_WIDTH      = (ENTRY_COUNT > 1) ? $clog2(ENTRY_COUNT) : 1;

    // One model instance with its compact transform
    typedef struct packed {
        logic [7:0]  model_id;
        logic [15:0] pos_x;
        logic [15:0] pos_y;
        logic [15:0] pos_z;
        logic [7:0]  rot;
    } modelinstance_t;

    // Side band travelling with each instance
    typedef struct packed {
        logic last;
    } modelinstance_meta_t;

    typedef logic [SCENE_IDX_WIDTH-1:0]     scene_idx_t;
    typedef logic [TRANSFORM_IDX_WIDTH-1:0] transform_idx_t;
    typedef logic [RAM_ADDR_WIDTH-1:0]      ram_addr_t;

    // Wrap point of the slot counters
    localparam scene_idx_t LAST_SCENE = scene_idx_t'(SCENE_COUNT - 1);

    // Index of the instance that fills a slot
    localparam transform_idx_t LAST_TRANSFORM = transform_idx_t'(TRANSFORM_COUNT - 1);

    localparam ram_addr_t SLOT_STRIDE = ram_addr_t'(TRANSFORM_COUNT);

endpackage

//--- hdl/scene_slot_table.sv
`timescale 1ns/100ps

module scene_slot_table
    import scene_pkg::*;
(
    input  logic                clk,
    input  logic                rstn,

    // Write side
    input  logic                write_valid,
    input  modelinstance_meta_t write_meta,
    input  scene_idx_t          write_slot,
    input  transform_idx_t      write_index,
    output logic                write_ready,
    output logic                write_step,
    output logic                write_close,

    // Read side
    input  scene_idx_t          read_slot,
    input  logic                retire,
    output logic                read_closed,
    output transform_idx_t      read_size
);

    transform_idx_t sizes  [SCENE_COUNT];
    logic           closed [SCENE_COUNT];

    logic slot_full;

    // A closed slot takes nothing until the reader retires it
    assign write_ready = !closed[write_slot];
    assign write_step  = write_valid && write_ready;

    // Capacity close keeps a never-terminated scene from blocking the writer
    assign slot_full   = (write_index == LAST_TRANSFORM);
    assign write_close = write_step && (write_meta.last || slot_full);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < SCENE_COUNT; i++) begin
                sizes[i]  <= '0;
                closed[i] <= 1'b0;
            end
        end else begin
            if (write_step) begin
                sizes[write_slot] <= write_index + transform_idx_t'(1);
                if (write_close) begin
                    closed[write_slot] <= 1'b1;
                end
            end

            // Never the write slot, that one is open whenever a write lands
            if (retire) begin
                sizes[read_slot]  <= '0;
                closed[read_slot] <= 1'b0;
            end
        end
    end

    assign read_closed = closed[read_slot];
    assign read_size   = sizes[read_slot];

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the scene buffer testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing \
    -f all.f \
    --top-module scene_buffer_tb \
    -o scene_buffer_sim

./obj_dir/scene_buffer_sim | tee sim.log

if grep -q "All tests passed!" sim.log; then
    echo "Simulation PASSED"
else
    echo "Simulation FAILED, see sim.log"
    exit 1
fi
